// File: hdl/eth_frame_pkg.sv
//################################################
// Ethernet frame types
// Stream byte, checksum fields and the receive
// status word with its field positions
//################################################

`default_nettype none

package eth_frame_pkg;

	typedef logic [7:0] frame_byte_t;

	typedef logic [15:0] csum_val_t;

	// Zero means no checksum to insert
	typedef logic [30:0] csum_pos_t;

	// {csum_val, csum_pos, drop, fcs_invalid}
	typedef logic [48:0] rx_user_t;

	localparam int FCS_INVALID_BIT = 0;
	localparam int DROP_BIT = 1;
	localparam int CSUM_POS_LSB = 2;
	localparam int CSUM_VAL_LSB = 33;

endpackage

`default_nettype wire

// File: hdl/eth_loop_pkg.sv
//################################################
// Loop stage state machines
// State encodings of the receive writer and the
// transmit reader
//################################################

`default_nettype none

package eth_loop_pkg;

	typedef enum logic [2:0] {
		wait_fifo,
		write_frame,
		write_ctl,
		overflow_close,
		overflow_ctl
	} loop_wr_state_t;

	typedef enum logic [1:0] {
		idle,
		forward,
		discard
	} loop_rd_state_t;

endpackage

`default_nettype wire

// File: hdl/axis_sync_fifo.sv
//################################################
// Synchronous stream FIFO
// Circular buffer with a registered show-ahead
// output and valid/ready on both sides
//################################################

`default_nettype none

module axis_sync_fifo #(
	parameter int WIDTH = 8,
	parameter int DEPTH = 16
) (
	input  logic             clk,
	input  logic             rst_n,

	input  logic [WIDTH-1:0] in_data,
	input  logic             in_valid,
	output logic             in_ready,

	output logic [WIDTH-1:0] out_data,
	output logic             out_valid,
	input  logic             out_ready
);
	localparam int AW = $clog2(DEPTH);

	logic [WIDTH-1:0] mem [DEPTH];
	logic [AW:0] wr_ptr;
	logic [AW:0] rd_ptr;

	logic mem_empty;
	logic mem_full;
	logic load_out;
	logic bypass;
	logic mem_wr;
	logic mem_rd;

	assign mem_empty = (wr_ptr == rd_ptr);
	assign mem_full = (wr_ptr[AW] != rd_ptr[AW]) && (wr_ptr[AW-1:0] == rd_ptr[AW-1:0]);

	assign in_ready = ~mem_full;

	// Output register is free or being emptied this cycle
	assign load_out = ~out_valid | out_ready;

	// Straight into the output register when nothing is queued ahead
	assign bypass = load_out & mem_empty & in_valid;
	assign mem_wr = in_valid & in_ready & ~bypass;
	assign mem_rd = load_out & ~mem_empty;

	always_ff @(posedge clk) begin
		if (mem_wr) begin
			mem[wr_ptr[AW-1:0]] <= in_data;
		end
	end

	always_ff @(posedge clk) begin
		if (bypass) begin
			out_data <= in_data;
		end else if (mem_rd) begin
			out_data <= mem[rd_ptr[AW-1:0]];
		end
	end

	always_ff @(posedge clk) begin
		if (~rst_n) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			out_valid <= 1'b0;
		end else begin
			if (mem_wr) begin
				wr_ptr <= wr_ptr + 1'b1;
			end
			if (mem_rd) begin
				rd_ptr <= rd_ptr + 1'b1;
			end
			if (load_out) begin
				out_valid <= bypass | ~mem_empty;
			end
		end
	end

endmodule

`default_nettype wire

// File: hdl/eth_frame_loop_fifo.sv
//################################################
// Loop buffer writer
// Steers received frames into the byte FIFO and
// their status words into the control FIFO
//################################################

`default_nettype none

module eth_frame_loop_fifo #(
	parameter int FRAME_DEPTH = 2048
) (
	input  logic                      clk,
	input  logic                      rst_n,

	input  eth_frame_pkg::frame_byte_t rx_data,
	input  eth_frame_pkg::rx_user_t    rx_user,
	input  logic                      rx_last,
	input  logic                      rx_valid,

	output eth_frame_pkg::frame_byte_t frame_data,
	output logic                      frame_last,
	output logic                      frame_valid,
	input  logic                      frame_ready,

	output eth_frame_pkg::rx_user_t    ctl_word,
	output logic                      ctl_valid,
	input  logic                      ctl_ready
);
	localparam int CTL_DEPTH = FRAME_DEPTH / 32;
	localparam int CNT_W = $clog2(FRAME_DEPTH);
	localparam logic [CNT_W-1:0] CNT_MAX = CNT_W'(FRAME_DEPTH - 1);

	eth_loop_pkg::loop_wr_state_t state;
	eth_loop_pkg::loop_wr_state_t state_next;

	logic [8:0] fifo_in_data;
	logic fifo_in_valid;
	logic fifo_in_ready;

	eth_frame_pkg::rx_user_t ctl_in;
	logic ctl_in_valid;
	logic ctl_in_ready;

	eth_frame_pkg::rx_user_t user_q;
	logic in_frame;
	logic [CNT_W-1:0] frame_cnt;
	logic room;

	// Keep one slot back so a cut frame can always be closed
	assign room = fifo_in_ready & (rx_last | (frame_cnt != CNT_MAX));

	always_ff @(posedge clk) begin
		if (~rst_n) begin
			state <= eth_loop_pkg::wait_fifo;
			in_frame <= 1'b0;
			frame_cnt <= '0;
		end else begin
			state <= state_next;

			// Bytes seen outside write_frame belong to a skipped frame
			if (state != eth_loop_pkg::write_frame) begin
				if (rx_valid) begin
					in_frame <= ~rx_last;
				end
			end else if (rx_valid & rx_last) begin
				in_frame <= 1'b0;
			end

			if (state != eth_loop_pkg::write_frame) begin
				frame_cnt <= '0;
			end else if (fifo_in_valid) begin
				frame_cnt <= frame_cnt + 1'b1;
			end
		end
	end

	// Status is only valid alongside the last byte
	always_ff @(posedge clk) begin
		if (state == eth_loop_pkg::write_frame && fifo_in_valid && rx_last) begin
			user_q <= rx_user;
		end
	end

	always_comb begin
		state_next = state;
		fifo_in_data = {rx_last, rx_data};
		fifo_in_valid = 1'b0;
		ctl_in = user_q;
		ctl_in_valid = 1'b0;

		case (state)
			eth_loop_pkg::wait_fifo: begin
				if (fifo_in_ready & ctl_in_ready) begin
					state_next = eth_loop_pkg::write_frame;
				end
			end

			eth_loop_pkg::write_frame: begin
				if (~in_frame & rx_valid) begin
					if (~room) begin
						state_next = eth_loop_pkg::overflow_close;
					end else begin
						fifo_in_valid = 1'b1;
						if (rx_last) begin
							state_next = eth_loop_pkg::write_ctl;
						end
					end
				end
			end

			eth_loop_pkg::write_ctl: begin
				ctl_in_valid = 1'b1;
				if (ctl_in_ready) begin
					state_next = eth_loop_pkg::wait_fifo;
				end
			end

			eth_loop_pkg::overflow_close: begin
				fifo_in_data = {1'b1, rx_data};
				fifo_in_valid = 1'b1;
				if (fifo_in_ready) begin
					state_next = eth_loop_pkg::overflow_ctl;
				end
			end

			eth_loop_pkg::overflow_ctl: begin
				ctl_in[eth_frame_pkg::DROP_BIT] = 1'b1;
				ctl_in[eth_frame_pkg::FCS_INVALID_BIT] = 1'b0;
				ctl_in_valid = 1'b1;
				if (ctl_in_ready) begin
					state_next = eth_loop_pkg::wait_fifo;
				end
			end

			default: begin
				state_next = eth_loop_pkg::wait_fifo;
			end
		endcase
	end

	axis_sync_fifo #(
		.WIDTH(9),
		.DEPTH(FRAME_DEPTH)
	) i_frame_fifo (
		.clk(clk),
		.rst_n(rst_n),
		.in_data(fifo_in_data),
		.in_valid(fifo_in_valid),
		.in_ready(fifo_in_ready),
		.out_data({frame_last, frame_data}),
		.out_valid(frame_valid),
		.out_ready(frame_ready)
	);

	axis_sync_fifo #(
		.WIDTH($bits(eth_frame_pkg::rx_user_t)),
		.DEPTH(CTL_DEPTH)
	) i_ctl_fifo (
		.clk(clk),
		.rst_n(rst_n),
		.in_data(ctl_in),
		.in_valid(ctl_in_valid),
		.in_ready(ctl_in_ready),
		.out_data(ctl_word),
		.out_valid(ctl_valid),
		.out_ready(ctl_ready)
	);

endmodule

`default_nettype wire

// File: hdl/eth_frame_tx.sv
//################################################
// Transmit reader
// Pairs each control word with its frame, drops
// flagged frames and inserts the checksum
//################################################

`default_nettype none

module eth_frame_tx (
	input  logic                      clk,
	input  logic                      rst_n,

	input  eth_frame_pkg::frame_byte_t frame_data,
	input  logic                      frame_last,
	input  logic                      frame_valid,
	output logic                      frame_ready,

	input  eth_frame_pkg::rx_user_t    ctl_word,
	input  logic                      ctl_valid,
	output logic                      ctl_ready,

	output eth_frame_pkg::frame_byte_t tx_data,
	output logic                      tx_last,
	output logic                      tx_valid,
	input  logic                      tx_ready
);
	eth_loop_pkg::loop_rd_state_t state;
	eth_loop_pkg::loop_rd_state_t state_next;

	eth_frame_pkg::csum_val_t csum_val_q;
	eth_frame_pkg::csum_pos_t csum_pos_q;
	eth_frame_pkg::csum_pos_t offset;

	logic ctl_accept;
	logic drop_frame;
	logic tx_beat;
	logic patch_hi;
	logic patch_lo;

	assign ctl_accept = ctl_valid & ctl_ready;
	assign drop_frame = ctl_word[eth_frame_pkg::DROP_BIT] |
		ctl_word[eth_frame_pkg::FCS_INVALID_BIT];
	assign tx_beat = tx_valid & tx_ready;

	// High byte at the given offset, low byte right after
	assign patch_hi = (csum_pos_q != '0) && (offset == csum_pos_q);
	assign patch_lo = (csum_pos_q != '0) &&
		(offset == eth_frame_pkg::csum_pos_t'(csum_pos_q + 1'b1));

	always_ff @(posedge clk) begin
		if (~rst_n) begin
			state <= eth_loop_pkg::idle;
			offset <= '0;
		end else begin
			state <= state_next;
			if (ctl_accept) begin
				offset <= '0;
			end else if (tx_beat) begin
				offset <= offset + 1'b1;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (ctl_accept) begin
			csum_val_q <= ctl_word[eth_frame_pkg::CSUM_VAL_LSB +: $bits(eth_frame_pkg::csum_val_t)];
			csum_pos_q <= ctl_word[eth_frame_pkg::CSUM_POS_LSB +: $bits(eth_frame_pkg::csum_pos_t)];
		end
	end

	always_comb begin
		state_next = state;
		ctl_ready = 1'b0;
		frame_ready = 1'b0;
		tx_valid = 1'b0;
		tx_last = frame_last;
		tx_data = frame_data;

		case (state)
			eth_loop_pkg::idle: begin
				ctl_ready = 1'b1;
				if (ctl_valid) begin
					if (drop_frame) begin
						state_next = eth_loop_pkg::discard;
					end else begin
						state_next = eth_loop_pkg::forward;
					end
				end
			end

			eth_loop_pkg::forward: begin
				tx_valid = frame_valid;
				frame_ready = tx_ready;
				if (patch_hi) begin
					tx_data = csum_val_q[15:8];
				end else if (patch_lo) begin
					tx_data = csum_val_q[7:0];
				end
				if (frame_valid & tx_ready & frame_last) begin
					state_next = eth_loop_pkg::idle;
				end
			end

			// Flush bytes one per cycle, nothing goes out
			eth_loop_pkg::discard: begin
				frame_ready = 1'b1;
				if (frame_valid & frame_last) begin
					state_next = eth_loop_pkg::idle;
				end
			end

			default: begin
				state_next = eth_loop_pkg::idle;
			end
		endcase
	end

endmodule

`default_nettype wire

// File: hdl/eth_loop_top.sv
//################################################
// Ethernet frame loop stage
// Loop buffer feeding the transmit reader
//################################################

`default_nettype none

module eth_loop_top #(
	parameter int FRAME_DEPTH = 2048
) (
	input  logic                      clk,
	input  logic                      rst_n,

	input  eth_frame_pkg::frame_byte_t rx_data,
	input  eth_frame_pkg::rx_user_t    rx_user,
	input  logic                      rx_last,
	input  logic                      rx_valid,

	output eth_frame_pkg::frame_byte_t tx_data,
	output logic                      tx_last,
	output logic                      tx_valid,
	input  logic                      tx_ready
);
	eth_frame_pkg::frame_byte_t frame_data;
	logic frame_last;
	logic frame_valid;
	logic frame_ready;

	eth_frame_pkg::rx_user_t ctl_word;
	logic ctl_valid;
	logic ctl_ready;

	eth_frame_loop_fifo #(
		.FRAME_DEPTH(FRAME_DEPTH)
	) i_loop_fifo (
		.clk(clk),
		.rst_n(rst_n),
		.rx_data(rx_data),
		.rx_user(rx_user),
		.rx_last(rx_last),
		.rx_valid(rx_valid),
		.frame_data(frame_data),
		.frame_last(frame_last),
		.frame_valid(frame_valid),
		.frame_ready(frame_ready),
		.ctl_word(ctl_word),
		.ctl_valid(ctl_valid),
		.ctl_ready(ctl_ready)
	);

	eth_frame_tx i_frame_tx (
		.clk(clk),
		.rst_n(rst_n),
		.frame_data(frame_data),
		.frame_last(frame_last),
		.frame_valid(frame_valid),
		.frame_ready(frame_ready),
		.ctl_word(ctl_word),
		.ctl_valid(ctl_valid),
		.ctl_ready(ctl_ready),
		.tx_data(tx_data),
		.tx_last(tx_last),
		.tx_valid(tx_valid),
		.tx_ready(tx_ready)
	);

endmodule

`default_nettype wire

// File: testbench/tb_eth_loop_assert.sv
//################################################
// Transmit reader assertions
// Output handshake, reset state and control
// word pairing, bound into the reader
//################################################

`default_nettype none

module tb_eth_loop_assert (
	input  logic                         clk,
	input  logic                         rst_n,
	input  logic                         frame_last,
	input  logic                         frame_valid,
	input  logic                         frame_ready,
	input  logic                         ctl_valid,
	input  eth_frame_pkg::frame_byte_t   tx_data,
	input  logic                         tx_last,
	input  logic                         tx_valid,
	input  logic                         tx_ready,
	input  logic                         ctl_ready,
	input  eth_loop_pkg::loop_rd_state_t state
);
	int fail_count = 0;

	logic busy;

	// A taken control word opens a frame, its last byte closes it
	always_ff @(posedge clk) begin
		if (~rst_n) begin
			busy <= 1'b0;
		end else if (ctl_valid && ctl_ready) begin
			busy <= 1'b1;
		end else if (frame_valid && frame_ready && frame_last) begin
			busy <= 1'b0;
		end
	end

	// An offered beat holds until taken
	a_tx_hold: assert property (@(posedge clk) disable iff (!rst_n)
		tx_valid && !tx_ready |=> tx_valid && $stable(tx_data) && $stable(tx_last))
	else begin
		$error("tx beat dropped or changed before tx_ready");
		fail_count++;
	end

	a_reset_quiet: assert property (@(posedge clk) !rst_n |=> !tx_valid)
	else begin
		$error("tx_valid high in the cycle after reset");
		fail_count++;
	end

	// No new control word while a frame is still being read
	a_ctl_idle: assert property (@(posedge clk) disable iff (!rst_n)
		ctl_ready |-> !busy && state == eth_loop_pkg::idle)
	else begin
		$error("ctl_ready high while a frame is still being read");
		fail_count++;
	end

endmodule

bind eth_frame_tx tb_eth_loop_assert i_assert (
	.clk(clk),
	.rst_n(rst_n),
	.frame_last(frame_last),
	.frame_valid(frame_valid),
	.frame_ready(frame_ready),
	.ctl_valid(ctl_valid),
	.tx_data(tx_data),
	.tx_last(tx_last),
	.tx_valid(tx_valid),
	.tx_ready(tx_ready),
	.ctl_ready(ctl_ready),
	.state(state)
);

`default_nettype wire

// File: testbench/tb_eth_loop_check.sv
//################################################
// Transmit checker
// Compares accepted tx beats with the queue of
// expected bytes and keeps the error counts
//################################################

`default_nettype none

module tb_eth_loop_check (
	input  logic                       clk,
	input  logic                       rst_n,
	input  eth_frame_pkg::frame_byte_t tx_data,
	input  logic                       tx_last,
	input  logic                       tx_valid,
	input  logic                       tx_ready
);
	// One entry per expected beat, last flag on top
	logic [8:0] exp_q [$];

	int mismatch_count = 0;
	int other_errors = 0;
	int beat_count = 0;

	task automatic push_expected(input eth_frame_pkg::frame_byte_t data, input logic last);
		exp_q.push_back({last, data});
	endtask

	function automatic int expected_left();
		return exp_q.size();
	endfunction

	task automatic report_timeout(input string what);
		$display("Timeout at time %0t: %s", $time, what);
		other_errors++;
	endtask

	task automatic check_leftover();
		if (exp_q.size() != 0) begin
			$display("%0d expected tx bytes never came out of the DUT", exp_q.size());
			other_errors++;
		end
	endtask

	task automatic print_summary(input int assert_fails);
		$display("Checked %0d tx beats: %0d mismatches, %0d other failures, %0d assertion failures",
			beat_count, mismatch_count, other_errors, assert_fails);
	endtask

	always @(posedge clk) begin
		logic [8:0] want;
		if (rst_n && tx_valid && tx_ready) begin
			beat_count++;
			if (exp_q.size() == 0) begin
				$display("Unexpected tx beat at time %0t while no frame was expected", $time);
				mismatch_count++;
			end else begin
				want = exp_q.pop_front();
				if (tx_data !== want[7:0]) begin
					$display("** Error at time %0t: tx_data expected 0x%02h, got 0x%02h",
						$time, want[7:0], tx_data);
					mismatch_count++;
				end
				if (tx_last !== want[8]) begin
					$display("** Error at time %0t: tx_last expected %0b, got %0b",
						$time, want[8], tx_last);
					mismatch_count++;
				end
			end
		end
	end

endmodule

`default_nettype wire

// File: testbench/tb_eth_loop.sv
//################################################
// Frame loop stage testbench
// Sends a table of frames and queues the bytes
// expected on the transmit side
//################################################

`default_nettype none

module tb_eth_loop;

	localparam int FRAME_DEPTH = 128;
	localparam int NUM_ROWS = 16;
	localparam int IDLE_CYCLES = 8;
	localparam int DRAIN_LIMIT = 4000;

	typedef struct packed {
		int          len;
		logic        drop;
		logic        fcs_bad;
		int          csum_pos;
		logic [15:0] csum_val;
		logic        hold_tx;
		logic        appears;
	} frame_row_t;

	// len, drop, fcs_bad, csum_pos, csum_val, hold_tx, appears
	localparam frame_row_t ROWS [NUM_ROWS] = '{
		'{1, 1'b0, 1'b0, 0, 16'h0000, 1'b0, 1'b1},
		'{2, 1'b0, 1'b0, 0, 16'h0000, 1'b0, 1'b1},
		'{17, 1'b0, 1'b0, 0, 16'h0000, 1'b0, 1'b1},
		'{64, 1'b1, 1'b0, 0, 16'h0000, 1'b0, 1'b0},
		'{33, 1'b0, 1'b0, 0, 16'h0000, 1'b0, 1'b1},
		'{40, 1'b0, 1'b1, 0, 16'h0000, 1'b0, 1'b0},
		'{12, 1'b1, 1'b1, 5, 16'hdead, 1'b0, 1'b0},
		'{60, 1'b0, 1'b0, 14, 16'hbeef, 1'b0, 1'b1},
		'{20, 1'b0, 1'b0, 1, 16'h1234, 1'b0, 1'b1},
		'{30, 1'b0, 1'b0, 28, 16'ha55a, 1'b0, 1'b1},
		'{128, 1'b0, 1'b0, 0, 16'h0000, 1'b0, 1'b1},
		'{200, 1'b0, 1'b0, 0, 16'h0000, 1'b1, 1'b0},
		'{46, 1'b0, 1'b0, 0, 16'h0000, 1'b0, 1'b1},
		'{90, 1'b0, 1'b0, 44, 16'hc0de, 1'b0, 1'b1},
		'{5, 1'b1, 1'b0, 0, 16'h0000, 1'b0, 1'b0},
		'{3, 1'b0, 1'b0, 1, 16'h0f0f, 1'b0, 1'b1}
	};

	logic clk;
	logic rst_n;
	eth_frame_pkg::frame_byte_t rx_data;
	eth_frame_pkg::rx_user_t rx_user;
	logic rx_last;
	logic rx_valid;
	eth_frame_pkg::frame_byte_t tx_data;
	logic tx_last;
	logic tx_valid;
	logic tx_ready;

	logic [31:0] lfsr;
	logic hold_tx;
	logic drained;
	logic aborted;

	eth_loop_top #(
		.FRAME_DEPTH(FRAME_DEPTH)
	) i_dut (
		.clk(clk),
		.rst_n(rst_n),
		.rx_data(rx_data),
		.rx_user(rx_user),
		.rx_last(rx_last),
		.rx_valid(rx_valid),
		.tx_data(tx_data),
		.tx_last(tx_last),
		.tx_valid(tx_valid),
		.tx_ready(tx_ready)
	);

	tb_eth_loop_check i_check (
		.clk(clk),
		.rst_n(rst_n),
		.tx_data(tx_data),
		.tx_last(tx_last),
		.tx_valid(tx_valid),
		.tx_ready(tx_ready)
	);

	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		if (s[0]) begin
			return (s >> 1) ^ 32'h8020_0003;
		end
		return s >> 1;
	endfunction

	task automatic take_bits(input int n, output logic [7:0] v);
		v = '0;
		for (int k = 0; k < n; k++) begin
			v = {v[6:0], lfsr[0]};
			lfsr = lfsr_next(lfsr);
		end
	endtask

	// One clock, with a fresh tx_ready unless it is held low
	task automatic tick();
		logic [7:0] r;
		@(posedge clk);
		if (hold_tx) begin
			tx_ready <= 1'b0;
		end else begin
			take_bits(2, r);
			tx_ready <= |r[1:0];
		end
	endtask

	function automatic eth_frame_pkg::frame_byte_t patched_byte(input frame_row_t row,
		input int idx, input eth_frame_pkg::frame_byte_t raw);
		if (row.csum_pos != 0 && idx == row.csum_pos) begin
			return row.csum_val[15:8];
		end
		if (row.csum_pos != 0 && idx == row.csum_pos + 1) begin
			return row.csum_val[7:0];
		end
		return raw;
	endfunction

	task automatic send_frame(input frame_row_t row);
		logic [7:0] b;
		logic last;
		hold_tx = row.hold_tx;
		for (int i = 0; i < row.len; i++) begin
			tick();
			take_bits(8, b);
			last = (i == row.len - 1);
			rx_valid <= 1'b1;
			rx_data <= b;
			rx_last <= last;
			// Status rides on the last byte only
			if (last) begin
				rx_user <= {row.csum_val, eth_frame_pkg::csum_pos_t'(row.csum_pos),
					row.drop, row.fcs_bad};
			end else begin
				rx_user <= '0;
			end
			if (row.appears) begin
				i_check.push_expected(patched_byte(row, i, b), last);
			end
		end
		tick();
		rx_valid <= 1'b0;
		rx_last <= 1'b0;
		rx_user <= '0;
		for (int i = 1; i < IDLE_CYCLES; i++) begin
			tick();
		end
		hold_tx = 1'b0;
	endtask

	task automatic wait_drain(output logic ok);
		int n;
		n = 0;
		while (i_check.expected_left() != 0 && n < DRAIN_LIMIT) begin
			tick();
			n++;
		end
		ok = (i_check.expected_left() == 0);
		if (!ok) begin
			i_check.report_timeout("transmit output did not drain");
		end
	endtask

	initial begin
		int assert_fails;
		lfsr = 32'h2d7d;
		hold_tx = 1'b0;
		aborted = 1'b0;
		rst_n <= 1'b0;
		rx_data <= '0;
		rx_user <= '0;
		rx_last <= 1'b0;
		rx_valid <= 1'b0;
		tx_ready <= 1'b0;

		for (int i = 0; i < 2; i++) begin
			tick();
		end
		rst_n <= 1'b1;
		for (int i = 0; i < 4; i++) begin
			tick();
		end

		for (int r = 0; r < NUM_ROWS && !aborted; r++) begin
			wait_drain(drained);
			if (drained) begin
				send_frame(ROWS[r]);
			end else begin
				aborted = 1'b1;
			end
		end
		if (!aborted) begin
			wait_drain(drained);
		end

		i_check.check_leftover();
		assert_fails = i_dut.i_frame_tx.i_assert.fail_count;
		i_check.print_summary(assert_fails);
		if (i_check.mismatch_count + i_check.other_errors + assert_fails == 0) begin
			$display("TEST RESULT: PASS");
		end else begin
			$display("TEST RESULT: FAIL");
		end
		$finish;
	end

endmodule

`default_nettype wire

// File: eth_loop.f
hdl/eth_frame_pkg.sv
hdl/eth_loop_pkg.sv
hdl/axis_sync_fifo.sv
hdl/eth_frame_loop_fifo.sv
hdl/eth_frame_tx.sv
hdl/eth_loop_top.sv
testbench/tb_eth_loop_assert.sv
testbench/tb_eth_loop_check.sv
testbench/tb_eth_loop.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Build and run the frame loop testbench with Verilator

cd "$(dirname "$0")" || exit 1

if ! command -v verilator > /dev/null 2>&1; then
	echo "verilator not found in PATH"
	exit 1
fi

if ! verilator --binary --timing --assert --top-module tb_eth_loop \
	-Mdir obj_dir -o tb_eth_loop -f eth_loop.f; then
	echo "Verilator build failed"
	exit 1
fi

sim_out=$(./obj_dir/tb_eth_loop)
sim_status=$?
echo "$sim_out"

if [ "$sim_status" -ne 0 ]; then
	echo "Simulation exited with status $sim_status"
	exit 1
fi

if grep -qx "TEST RESULT: PASS" <<< "$sim_out"; then
	exit 0
fi
exit 1
